/* fetch_subsys.f */
logic/bus_pkg.sv
logic/isa_pkg.sv
logic/ibus_if.sv
logic/bank_if.sv
logic/insn_bank.sv
logic/bank_router.sv
logic/bank_merge.sv
logic/fetch_unit.sv
logic/fetch_subsys.sv
bench/fetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --assert
TOP       := fetch_tb
FILELIST  := fetch_subsys.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* bench/fetch_tb.sv */
module fetch_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import bus_pkg::*;
   import isa_pkg::*;

   localparam int MEM_WORDS = DEF_NUM_BANKS * DEF_BANK_DEPTH;
   localparam int RESET_CYCLES = 10;
   localparam int RANDOM_ADV = 40;
   // upper bound on advances issued by the stimulus
   localparam int NUM_ADV = 80;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + MEM_WORDS + NUM_ADV * 20;

   typedef logic [31:0] word_arr_t [MEM_WORDS];

   logic        clk;
   logic        rst = 1'b1;
   logic        load_we_i;
   logic [31:0] load_adr_i;
   logic [31:0] load_dat_i;
   logic        padv_i;
   logic        branch_occur_i;
   logic [31:0] branch_dest_i;
   logic        du_restart_i;
   logic [31:0] du_restart_pc_i;
   logic [31:0] decode_insn_o;
   logic [4:0]  fetch_rfa_adr_o;
   logic [4:0]  fetch_rfb_adr_o;
   logic [31:0] pc_fetch_o;
   logic        next_fetch_done_o;
   logic        decode_except_ibus_err_o;
   logic        fetch_advancing_o;

   // model of the bank contents, by word address
   word_arr_t   model_mem;
   int          adv_issued;
   int          adv_checked;

   // values held just before the rising edge
   logic        s_adv;
   logic        s_br;
   logic        s_rs;
   logic [31:0] s_dest;
   logic [31:0] s_rpc;
   logic [31:0] s_pc;
   logic [31:0] s_dec;

   fetch_subsys i_dut (
      .clk                      (clk),
      .rst                      (rst),
      .load_we_i                (load_we_i),
      .load_adr_i               (load_adr_i),
      .load_dat_i               (load_dat_i),
      .padv_i                   (padv_i),
      .branch_occur_i           (branch_occur_i),
      .branch_dest_i            (branch_dest_i),
      .du_restart_i             (du_restart_i),
      .du_restart_pc_i          (du_restart_pc_i),
      .decode_insn_o            (decode_insn_o),
      .fetch_rfa_adr_o          (fetch_rfa_adr_o),
      .fetch_rfb_adr_o          (fetch_rfb_adr_o),
      .pc_fetch_o               (pc_fetch_o),
      .next_fetch_done_o        (next_fetch_done_o),
      .decode_except_ibus_err_o (decode_except_ibus_err_o),
      .fetch_advancing_o        (fetch_advancing_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // expected word and error for a fetch at pc
   function automatic void fetch_ref(input logic [31:0] pc, input word_arr_t mem,
                                     output logic [31:0] exp_word, output logic exp_err);
      logic [31:0] widx;
      widx = pc >> 2;
      exp_word = '0;
      exp_err = 1'b0;
      if (pc[1:0] != 2'b00 || widx >= 32'(MEM_WORDS)) begin
         exp_err = 1'b1;
      end else begin
         exp_word = mem[widx];
      end
   endfunction

   // aligned byte address inside the banks, margin words short of the top
   function automatic logic [31:0] random_code_addr(input int margin);
      return $urandom_range(0, MEM_WORDS - 1 - margin) << 2;
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         $display("Test FAILED");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   task automatic load_program();
      logic [31:0] w;
      for (int i = 0; i < MEM_WORDS; i++) begin
         w = $urandom();
         load_we_i = 1'b1;
         load_adr_i = 32'(i);
         load_dat_i = w;
         model_mem[i] = w;
         @(negedge clk);
      end
      load_we_i = 1'b0;
   endtask

   // wait for the fetch, stall a little, then advance once
   task automatic advance_pipeline(input logic br, input logic [31:0] dest,
                                   input logic rs, input logic [31:0] rpc);
      int idle;
      idle = $urandom_range(0, 3);
      while (!next_fetch_done_o) @(negedge clk);
      repeat (idle) @(negedge clk);
      padv_i = 1'b1;
      branch_occur_i = br;
      branch_dest_i = dest;
      du_restart_i = rs;
      du_restart_pc_i = rpc;
      adv_issued++;
      @(negedge clk);
      padv_i = 1'b0;
      branch_occur_i = 1'b0;
      du_restart_i = 1'b0;
   endtask

   initial begin : compare_proc
      logic [31:0] exp_word;
      logic        exp_err;
      logic [31:0] exp_pc;
      logic        measuring;
      int          lat_cnt;
      measuring = 1'b0;
      lat_cnt = 0;
      wait (rst === 1'b0);
      forever begin
         // inputs driven on the falling edge have settled by now
         #1;
         s_adv = fetch_advancing_o;
         s_br = branch_occur_i;
         s_rs = du_restart_i;
         s_dest = branch_dest_i;
         s_rpc = du_restart_pc_i;
         s_pc = pc_fetch_o;
         s_dec = decode_insn_o;
         compare_value("fetch_advancing_o", 32'(fetch_advancing_o), 32'(padv_i));
         @(negedge clk);
         if (s_adv) begin
            fetch_ref(s_pc, model_mem, exp_word, exp_err);
            exp_pc = s_rs ? s_rpc : (s_br ? s_dest : s_pc + 32'd4);
            compare_value("pc_fetch_o", pc_fetch_o, exp_pc);
            compare_value("decode_except_ibus_err_o", 32'(decode_except_ibus_err_o),
                          32'(s_br ? 1'b0 : exp_err));
            // the very first advance hands over a word fetched before loading
            if (adv_checked > 0 && !exp_err) begin
               compare_value("decode_insn_o", decode_insn_o, exp_word);
            end
            compare_value("next_fetch_done_o", 32'(next_fetch_done_o), 32'd0);
            lat_cnt = 0;
            measuring = 1'b1;
            adv_checked++;
         end else begin
            // stall: decode side holds
            compare_value("decode_insn_o", decode_insn_o, s_dec);
            compare_value("pc_fetch_o", pc_fetch_o, s_pc);
            if (measuring) begin
               lat_cnt++;
               if (next_fetch_done_o) begin
                  compare_value("next_fetch_done_o latency", 32'(lat_cnt), 32'd2);
                  fetch_ref(pc_fetch_o, model_mem, exp_word, exp_err);
                  compare_value("decode_except_ibus_err_o", 32'(decode_except_ibus_err_o),
                                32'(exp_err));
                  if (!exp_err) begin
                     compare_value("fetch_rfa_adr_o", 32'(fetch_rfa_adr_o),
                                   32'(exp_word[20:16]));
                     compare_value("fetch_rfb_adr_o", 32'(fetch_rfb_adr_o),
                                   32'(exp_word[15:11]));
                  end
                  measuring = 1'b0;
               end
            end
         end
      end
   end

   initial begin : stimulus
      logic br;
      logic rs;
      load_we_i = 1'b0;
      load_adr_i = '0;
      load_dat_i = '0;
      padv_i = 1'b0;
      branch_occur_i = 1'b0;
      branch_dest_i = '0;
      du_restart_i = 1'b0;
      du_restart_pc_i = '0;
      adv_issued = 0;
      adv_checked = 0;
      void'($urandom(32'he3b4005f));
      repeat (RESET_CYCLES) @(negedge clk);
      rst = 1'b0;
      while (!next_fetch_done_o) @(negedge clk);
      load_program();

      // restart into the loaded program
      advance_pipeline(1'b0, '0, 1'b1, DEF_RESET_PC);
      repeat (12) advance_pipeline(1'b0, '0, 1'b0, '0);

      advance_pipeline(1'b1, random_code_addr(8), 1'b0, '0);
      repeat (5) advance_pipeline(1'b0, '0, 1'b0, '0);

      // restart and branch together
      advance_pipeline(1'b1, random_code_addr(8), 1'b1, random_code_addr(8));
      repeat (4) advance_pipeline(1'b0, '0, 1'b0, '0);

      // row past the last bank row, then back
      advance_pipeline(1'b1, 32'(MEM_WORDS * 4 + 16), 1'b0, '0);
      repeat (2) advance_pipeline(1'b0, '0, 1'b0, '0);
      advance_pipeline(1'b1, random_code_addr(8), 1'b0, '0);
      advance_pipeline(1'b0, '0, 1'b0, '0);

      // misaligned target, then back
      advance_pipeline(1'b1, random_code_addr(8) | 32'h2, 1'b0, '0);
      advance_pipeline(1'b0, '0, 1'b0, '0);
      advance_pipeline(1'b1, random_code_addr(8), 1'b0, '0);
      repeat (2) advance_pipeline(1'b0, '0, 1'b0, '0);

      repeat (RANDOM_ADV) begin
         br = ($urandom_range(0, 3) == 0);
         rs = ($urandom_range(0, 7) == 0);
         advance_pipeline(br, random_code_addr(0), rs, random_code_addr(0));
      end

      while (!next_fetch_done_o) @(negedge clk);
      @(negedge clk);
      compare_value("advance count", 32'(adv_checked), 32'(adv_issued));
      $display("Test OK");
      $finish;
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("fetch never completed, watchdog expired after %0d cycles", WATCHDOG_CYCLES);
      $display("Test FAILED");
      $fatal(1, "watchdog timeout");
   end

endmodule

/* logic/fetch_subsys.sv */
module fetch_subsys #(
   parameter int NUM_BANKS  = bus_pkg::DEF_NUM_BANKS,
   parameter int BANK_DEPTH = bus_pkg::DEF_BANK_DEPTH,
   parameter logic [bus_pkg::ADDR_WIDTH-1:0] RESET_PC = bus_pkg::DEF_RESET_PC
) (
   input  logic                              clk,
   input  logic                              rst,

   // bank load port
   input  logic                              load_we_i,
   input  logic [bus_pkg::ADDR_WIDTH-1:0]    load_adr_i,
   input  logic [isa_pkg::INSN_WIDTH-1:0]    load_dat_i,

   // pipeline control
   input  logic                              padv_i,
   input  logic                              branch_occur_i,
   input  logic [bus_pkg::ADDR_WIDTH-1:0]    branch_dest_i,
   input  logic                              du_restart_i,
   input  logic [bus_pkg::ADDR_WIDTH-1:0]    du_restart_pc_i,

   // decode side
   output logic [isa_pkg::INSN_WIDTH-1:0]    decode_insn_o,
   output logic [isa_pkg::RF_ADDR_WIDTH-1:0] fetch_rfa_adr_o,
   output logic [isa_pkg::RF_ADDR_WIDTH-1:0] fetch_rfb_adr_o,
   output logic [bus_pkg::ADDR_WIDTH-1:0]    pc_fetch_o,
   output logic                              next_fetch_done_o,
   output logic                              decode_except_ibus_err_o,
   output logic                              fetch_advancing_o
);

   logic misalign_stb;

   ibus_if ibus ();
   bank_if bank_bus [NUM_BANKS-1:0] ();

   fetch_unit #(
      .RESET_PC (RESET_PC)
   ) i_fetch (
      .clk                      (clk),
      .rst                      (rst),
      .bus                      (ibus),
      .padv_i                   (padv_i),
      .branch_occur_i           (branch_occur_i),
      .branch_dest_i            (branch_dest_i),
      .du_restart_i             (du_restart_i),
      .du_restart_pc_i          (du_restart_pc_i),
      .decode_insn_o            (decode_insn_o),
      .fetch_rfa_adr_o          (fetch_rfa_adr_o),
      .fetch_rfb_adr_o          (fetch_rfb_adr_o),
      .pc_fetch_o               (pc_fetch_o),
      .next_fetch_done_o        (next_fetch_done_o),
      .decode_except_ibus_err_o (decode_except_ibus_err_o),
      .fetch_advancing_o        (fetch_advancing_o)
   );

   bank_router #(
      .NUM_BANKS  (NUM_BANKS),
      .BANK_DEPTH (BANK_DEPTH)
   ) i_router (
      .clk            (clk),
      .rst            (rst),
      .bus            (ibus),
      .banks          (bank_bus),
      .load_we_i      (load_we_i),
      .load_adr_i     (load_adr_i),
      .load_dat_i     (load_dat_i),
      .misalign_stb_o (misalign_stb)
   );

   // one bank per interleave slot
   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      insn_bank #(
         .BANK_DEPTH (BANK_DEPTH)
      ) i_bank (
         .clk  (clk),
         .rst  (rst),
         .port (bank_bus[b])
      );
   end

   bank_merge #(
      .NUM_BANKS (NUM_BANKS)
   ) i_merge (
      .clk            (clk),
      .rst            (rst),
      .banks          (bank_bus),
      .misalign_stb_i (misalign_stb),
      .bus            (ibus)
   );

endmodule

/* logic/fetch_unit.sv */
module fetch_unit #(
   parameter logic [bus_pkg::ADDR_WIDTH-1:0] RESET_PC = bus_pkg::DEF_RESET_PC
) (
   input  logic                             clk,
   input  logic                             rst,

   ibus_if.fetch                            bus,

   // pipeline control
   input  logic                             padv_i,
   input  logic                             branch_occur_i,
   input  logic [bus_pkg::ADDR_WIDTH-1:0]   branch_dest_i,
   input  logic                             du_restart_i,
   input  logic [bus_pkg::ADDR_WIDTH-1:0]   du_restart_pc_i,

   // decode side
   output logic [isa_pkg::INSN_WIDTH-1:0]   decode_insn_o,
   output logic [isa_pkg::RF_ADDR_WIDTH-1:0] fetch_rfa_adr_o,
   output logic [isa_pkg::RF_ADDR_WIDTH-1:0] fetch_rfb_adr_o,
   output logic [bus_pkg::ADDR_WIDTH-1:0]   pc_fetch_o,
   output logic                             next_fetch_done_o,
   output logic                             decode_except_ibus_err_o,
   output logic                             fetch_advancing_o
);
   import bus_pkg::*;
   import isa_pkg::*;

   logic [ADDR_WIDTH-1:0] pc_fetch;
   logic [ADDR_WIDTH-1:0] pc_fetch_next;
   logic                  fetch_req;
   logic [INSN_WIDTH-1:0] insn_buffer;
   logic                  bus_access_done;

   assign bus_access_done = bus.ack | bus.err;
   assign pc_fetch_next = pc_fetch + ADDR_WIDTH'(4);

   assign bus.req = fetch_req;
   assign bus.adr = pc_fetch;

   assign pc_fetch_o = pc_fetch;
   assign next_fetch_done_o = ~fetch_req;
   assign fetch_advancing_o = padv_i & next_fetch_done_o;

   // register addresses straight from the buffered word
   assign fetch_rfa_adr_o = insn_buffer[RA_MSB:RA_LSB];
   assign fetch_rfb_adr_o = insn_buffer[RB_MSB:RB_LSB];

   // restart beats branch, branch beats sequential
   always_ff @(posedge clk) begin
      if (rst) begin
         pc_fetch <= RESET_PC;
      end else if (padv_i) begin
         if (du_restart_i) begin
            pc_fetch <= du_restart_pc_i;
         end else if (branch_occur_i) begin
            pc_fetch <= branch_dest_i;
         end else begin
            pc_fetch <= pc_fetch_next;
         end
      end
   end

   // request stays up until the fabric answers
   always_ff @(posedge clk) begin
      if (rst) begin
         fetch_req <= 1'b1;
      end else if (padv_i) begin
         fetch_req <= 1'b1;
      end else if (bus_access_done) begin
         fetch_req <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         insn_buffer <= NOP_INSN;
      end else if (bus.ack) begin
         insn_buffer <= bus.dat;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         decode_insn_o <= NOP_INSN;
      end else if (padv_i) begin
         decode_insn_o <= insn_buffer;
      end
   end

   // a taken branch drops any pending fetch error
   always_ff @(posedge clk) begin
      if (rst) begin
         decode_except_ibus_err_o <= 1'b0;
      end else if (padv_i && branch_occur_i) begin
         decode_except_ibus_err_o <= 1'b0;
      end else if (fetch_req) begin
         decode_except_ibus_err_o <= bus.err;
      end
   end

endmodule

/* logic/bank_merge.sv */
module bank_merge #(
   parameter int NUM_BANKS = bus_pkg::DEF_NUM_BANKS
) (
   input  logic   clk,
   input  logic   rst,

   bank_if.merge  banks [NUM_BANKS-1:0],
   input  logic   misalign_stb_i,

   ibus_if.fabric bus
);
   import isa_pkg::*;

   logic [NUM_BANKS-1:0]  ack_vec;
   logic [NUM_BANKS-1:0]  err_vec;
   logic [INSN_WIDTH-1:0] sel_dat [NUM_BANKS];
   logic [INSN_WIDTH-1:0] dat_or;
   logic                  misalign_err;

   // misaligned fetch answers one cycle after its strobe, like a bank
   always_ff @(posedge clk) begin
      if (rst) begin
         misalign_err <= 1'b0;
      end else begin
         misalign_err <= misalign_stb_i;
      end
   end

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      assign ack_vec[b] = banks[b].ack;
      assign err_vec[b] = banks[b].err;
      assign sel_dat[b] = banks[b].ack ? banks[b].rdat : '0;
   end

   // at most one bank acks at a time
   always_comb begin
      dat_or = '0;
      for (int i = 0; i < NUM_BANKS; i++) begin
         dat_or = dat_or | sel_dat[i];
      end
   end

   assign bus.ack = |ack_vec;
   assign bus.err = (|err_vec) | misalign_err;
   assign bus.dat = dat_or;

endmodule

/* logic/bank_router.sv */
module bank_router #(
   parameter int NUM_BANKS  = bus_pkg::DEF_NUM_BANKS,
   parameter int BANK_DEPTH = bus_pkg::DEF_BANK_DEPTH
) (
   input  logic                           clk,
   input  logic                           rst,

   ibus_if.fabric                         bus,
   bank_if.router                         banks [NUM_BANKS-1:0],

   // load port, word index rather than byte address
   input  logic                           load_we_i,
   input  logic [bus_pkg::ADDR_WIDTH-1:0] load_adr_i,
   input  logic [isa_pkg::INSN_WIDTH-1:0] load_dat_i,

   output logic                           misalign_stb_o
);
   import bus_pkg::*;

   localparam int BANK_SHIFT = $clog2(NUM_BANKS);
   localparam logic [ADDR_WIDTH-1:0] BANK_MASK = ADDR_WIDTH'(NUM_BANKS - 1);

   typedef enum logic {
      ST_IDLE,
      ST_WAIT
   } state_e;

   state_e                state;
   logic                  issue;
   logic                  aligned;
   logic [ADDR_WIDTH-1:0] fetch_word;
   logic [ADDR_WIDTH-1:0] fetch_bank;
   logic [ADDR_WIDTH-1:0] fetch_row;
   logic [ADDR_WIDTH-1:0] load_bank;
   logic [ADDR_WIDTH-1:0] load_row;
   logic                  load_ok;

   // one strobe per level request
   assign issue = (state == ST_IDLE) && bus.req;
   assign aligned = (bus.adr[WORD_OFS_BITS-1:0] == '0);
   assign misalign_stb_o = issue && !aligned;

   // word interleave: low word bits pick the bank
   assign fetch_word = bus.adr >> WORD_OFS_BITS;
   assign fetch_bank = fetch_word & BANK_MASK;
   assign fetch_row = fetch_word >> BANK_SHIFT;

   assign load_bank = load_adr_i & BANK_MASK;
   assign load_row = load_adr_i >> BANK_SHIFT;
   // drop loads past the end of the banks
   assign load_ok = (load_row < ADDR_WIDTH'(BANK_DEPTH));

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (bus.req) state <= ST_WAIT;
            ST_WAIT: if (bus.ack || bus.err) state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      assign banks[b].rd_stb = issue && aligned && (fetch_bank == ADDR_WIDTH'(b));
      assign banks[b].wr_stb = load_we_i && load_ok && (load_bank == ADDR_WIDTH'(b));
      assign banks[b].row = load_we_i ? load_row : fetch_row;
      assign banks[b].wdat = load_dat_i;
   end

endmodule

/* logic/insn_bank.sv */
module insn_bank #(
   parameter int BANK_DEPTH = bus_pkg::DEF_BANK_DEPTH
) (
   input  logic clk,
   input  logic rst,

   bank_if.bank port
);
   import isa_pkg::*;

   localparam int ROW_WIDTH = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

   logic [INSN_WIDTH-1:0] mem [BANK_DEPTH];
   logic [ROW_WIDTH-1:0]  row_idx;
   logic                  in_range;

   assign row_idx = port.row[ROW_WIDTH-1:0];
   // rows past the depth answer with an error
   assign in_range = (port.row < 32'(BANK_DEPTH));

   always_ff @(posedge clk) begin
      if (port.wr_stb) begin
         mem[row_idx] <= port.wdat;
      end
   end

   // read word, no reset
   always_ff @(posedge clk) begin
      if (port.rd_stb && in_range) begin
         port.rdat <= mem[row_idx];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         port.ack <= 1'b0;
         port.err <= 1'b0;
      end else begin
         port.ack <= port.rd_stb && in_range;
         port.err <= port.rd_stb && !in_range;
      end
   end

endmodule

/* logic/bank_if.sv */
interface bank_if;
   import bus_pkg::*;
   import isa_pkg::*;

   // strobes and row from the router
   logic                  rd_stb;
   logic                  wr_stb;
   // full row index, so that the bank can spot rows past its depth
   logic [ADDR_WIDTH-1:0] row;
   logic [INSN_WIDTH-1:0] wdat;

   // registered response from the bank
   logic                  ack;
   logic                  err;
   logic [INSN_WIDTH-1:0] rdat;

   modport router (
      output rd_stb,
      output wr_stb,
      output row,
      output wdat
   );

   modport bank (
      input  rd_stb,
      input  wr_stb,
      input  row,
      input  wdat,
      output ack,
      output err,
      output rdat
   );

   modport merge (
      input ack,
      input err,
      input rdat
   );

endinterface

/* logic/ibus_if.sv */
interface ibus_if;
   import bus_pkg::*;
   import isa_pkg::*;

   // level request, held until ack or err
   logic                  req;
   logic [ADDR_WIDTH-1:0] adr;

   // one-cycle response pulses
   logic                  ack;
   logic                  err;
   logic [INSN_WIDTH-1:0] dat;

   modport fetch (
      output req,
      output adr,
      input  ack,
      input  err,
      input  dat
   );

   modport fabric (
      input  req,
      input  adr,
      output ack,
      output err,
      output dat
   );

endinterface

/* logic/isa_pkg.sv */
package isa_pkg;

   // instruction word
   localparam int INSN_WIDTH = 32;
   localparam int OPC_WIDTH = 6;

   // register file
   localparam int RF_ADDR_WIDTH = 5;

   // major opcodes seen by the front end
   typedef enum logic [OPC_WIDTH-1:0] {
      OPC_J   = 6'h00,
      OPC_JAL = 6'h01,
      OPC_BNF = 6'h03,
      OPC_BF  = 6'h04,
      OPC_NOP = 6'h05
   } opcode_e;

   // opcode field position
   localparam int OPC_MSB = INSN_WIDTH - 1;
   localparam int OPC_LSB = INSN_WIDTH - OPC_WIDTH;

   // source register fields, read early from the fetch buffer
   localparam int RA_MSB = 20;
   localparam int RA_LSB = 16;
   localparam int RB_MSB = 15;
   localparam int RB_LSB = 11;

   // nop with an all-zero immediate
   localparam logic [INSN_WIDTH-1:0] NOP_INSN = {OPC_NOP, {(INSN_WIDTH - OPC_WIDTH){1'b0}}};

endpackage

/* logic/bus_pkg.sv */
package bus_pkg;

   // byte addresses on the instruction bus
   localparam int ADDR_WIDTH = 32;

   // byte offset inside a 32-bit word
   localparam int WORD_OFS_BITS = 2;

   // default bank geometry
   localparam int DEF_NUM_BANKS = 4;
   localparam int DEF_BANK_DEPTH = 64;

   // reset vector
   localparam logic [ADDR_WIDTH-1:0] DEF_RESET_PC = 32'h100;

endpackage
